/* bench/sub_cpu_bus_tb.sv */
`include "sub_bus_defs.svh"

module sub_cpu_bus_tb
	import bus_pkg::*;
	import video_reg_pkg::*;
;

	// vblank pulse shape in pixel clocks
	localparam int vb_high = 16;
	localparam int vb_low  = 112;
	localparam int n_sel   = 300;
	localparam int n_wr    = 60;
	// reset, selects, spaced writes plus drain, burst and ten vblank periods
	localparam int test_len = 8 + n_sel + n_wr * 6 + 14 + 32 + 10 * (vb_high + vb_low) + 16;
	localparam int max_cycles = 2 * test_len;
	localparam logic [31:0] seed = 32'd71384;

	logic        clk_6m;
	logic        rst;
	logic        vblk;
	logic        we;
	logic        acc;
	logic [15:0] a;
	logic [7:0]  d;
	cpu_phase_t  phase;
	chip_sel_t   sel;
	logic        res;
	logic        irq;
	video_regs_t regs;
	logic        overflow;

	// bench state
	logic [31:0] rng_state;
	logic [1:0]  ph_model;
	video_regs_t exp_regs;
	logic        chk_regs;
	logic        chk_ovf;
	int          cycle_cnt;
	int          mismatch_cnt;
	int          fail_cnt;
	logic [15:0] r_tmp;
	logic [15:0] r_addr;
	logic [7:0]  r_data;
	logic [5:0]  r_region;

	sub_cpu_bus dut_i (
		.clk_6m   (clk_6m),
		.rst      (rst),
		.vblk     (vblk),
		.we       (we),
		.acc      (acc),
		.a        (a),
		.d        (d),
		.phase    (phase),
		.sel      (sel),
		.res      (res),
		.irq      (irq),
		.regs     (regs),
		.overflow (overflow)
	);

	always #20 clk_6m = ~clk_6m;

	////////////////////////////////////////////////////////////////////////////
	// reference models
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [15:0] rand16();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[31:16];
	endfunction

	function automatic logic [1:0] next_count(input logic [1:0] c);
		return c + 2'd1;
	endfunction

	// e/q pattern for each of the four counts
	function automatic cpu_phase_t phase_of(input logic [1:0] c);
		cpu_phase_t p;
		p.e_main = (c == 2'd2) || (c == 2'd3);
		p.q_main = (c == 2'd1) || (c == 2'd2);
		p.e_sub  = (c == 2'd0) || (c == 2'd1);
		p.q_sub  = (c == 2'd3) || (c == 2'd0);
		return p;
	endfunction

	function automatic chip_sel_t sel_ref(input logic [15:0] addr, input logic wr);
		chip_sel_t s;
		s.scr0  = (addr[15:13] == 3'd0);
		s.scr1  = (addr[15:13] == 3'd1);
		s.obj   = (addr[15:13] == 3'd2);
		// sound ram overlaps the sprite window
		s.snd   = (addr[15:10] == 6'b010000);
		s.spgm  = !wr && (addr[15:13] == 3'd3);
		s.mpgm  = !wr && addr[15];
		s.bank  = wr && (addr[15:10] == `REGION_BANK);
		s.lth0  = wr && (addr[15:10] == `REGION_LTH0);
		s.lth1  = wr && (addr[15:10] == `REGION_LTH1);
		s.lth2  = wr && (addr[15:10] == `REGION_LTH2);
		s.bufen = s.scr0 | s.scr1 | s.obj | s.snd | s.lth0 | s.lth1;
		return s;
	endfunction

	// latch file after one cpu write in bus order
	function automatic video_regs_t apply_write(input video_regs_t r, input logic [15:0] addr,
			input logic [7:0] data);
		logic [5:0] region;
		logic [2:0] off;
		int         idx;
		region = addr[15:10];
		off = addr[2:0];
		if (region == `REGION_LTH0 || region == `REGION_LTH1) begin
			// lth1 serves layers 2 and 3
			// upper offsets go to the odd layer of the pair
			idx = (region == `REGION_LTH1) ? 2 : 0;
			if (off[2]) begin
				idx = idx + 1;
			end
			case (off)
				3'd0, 3'd4: begin
					r.layer[idx].x[8] = data[0];
					r.layer[idx].pri = data[3:1];
				end
				3'd1, 3'd5: begin
					r.layer[idx].x[7:0] = data;
				end
				3'd2, 3'd6: begin
					r.layer[idx].y = data;
				end
				3'd3: begin
					if (region == `REGION_LTH1) begin
						r.rom_bank_12d = data[2:0];
					end else begin
						r.rom_bank_9d = data[2:0];
					end
				end
				default: begin
					// offset 7 has no latch
				end
			endcase
		end else if (region == `REGION_LTH2) begin
			r.back_color = data;
		end else if (region == `REGION_BANK) begin
			r.tile_bank = data[0];
		end
		return r;
	endfunction

	function automatic logic probe(input int which);
		case (which)
			0: return irq;
			1: return res;
			default: return overflow;
		endcase
	endfunction

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] exp);
		mismatch_cnt++;
		$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
	endtask

	// one sub cpu write with acc high for a single cycle
	task automatic bus_write(input logic [15:0] addr, input logic [7:0] data);
		@(posedge clk_6m);
		a   <= addr;
		d   <= data;
		we  <= 1'b1;
		acc <= 1'b1;
		@(posedge clk_6m);
		acc <= 1'b0;
		we  <= 1'b0;
	endtask

	// waits for a level on irq (0), res (1) or overflow (2)
	task automatic expect_within(input int which, input logic want, input int cycles,
			input string what);
		logic seen;
		seen = 1'b0;
		for (int i = 0; i < cycles && !seen; i++) begin
			@(negedge clk_6m);
			seen = (probe(which) === want);
			if (!seen) begin
				@(posedge clk_6m);
			end
		end
		assert (seen) else begin
			fail_cnt++;
			$display("at %0t: %s did not happen within %0d cycles", $time, what, cycles);
		end
	endtask

	task automatic vblank_pulse();
		@(posedge clk_6m);
		vblk <= 1'b1;
		repeat (vb_high) @(posedge clk_6m);
		vblk <= 1'b0;
		repeat (vb_low) @(posedge clk_6m);
	endtask

	////////////////////////////////////////////////////////////////////////////
	// compare process
	////////////////////////////////////////////////////////////////////////////

	// own phase counter stepped like the bus clock
	always @(posedge clk_6m) begin
		if (rst) begin
			ph_model <= 2'd0;
		end else begin
			ph_model <= next_count(ph_model);
		end
	end

	// outputs are sampled mid-cycle away from the driving edge
	always @(negedge clk_6m) begin
		if (!rst) begin
			assert (phase === phase_of(ph_model)) else
				report_mismatch("phase", phase, phase_of(ph_model));
			assert (sel === sel_ref(a, we)) else
				report_mismatch("sel", sel, sel_ref(a, we));
			if (chk_regs) begin
				assert (regs === exp_regs) else
					report_mismatch("regs", regs, exp_regs);
			end
			if (chk_ovf) begin
				assert (overflow === 1'b1) else
					report_mismatch("overflow", overflow, 1'b1);
			end
		end
	end

	always @(posedge clk_6m) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= max_cycles) begin
			$display("timeout, run exceeded %0d cycles", max_cycles);
			$display(">>> FAIL");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// stimulus
	////////////////////////////////////////////////////////////////////////////

	initial begin
		clk_6m       = 1'b0;
		rst          = 1'b1;
		vblk         = 1'b0;
		we           = 1'b0;
		acc          = 1'b0;
		a            = 16'h0000;
		d            = 8'h00;
		rng_state    = seed;
		exp_regs     = '0;
		chk_regs     = 1'b0;
		chk_ovf      = 1'b0;
		cycle_cnt    = 0;
		mismatch_cnt = 0;
		fail_cnt     = 0;

		repeat (8) @(posedge clk_6m);
		rst <= 1'b0;

		// random decode with acc held low so nothing is written
		for (int i = 0; i < n_sel; i++) begin
			@(posedge clk_6m);
			r_tmp = rand16();
			a  <= rand16();
			we <= r_tmp[0];
		end
		@(posedge clk_6m);
		we <= 1'b0;

		// spaced latch writes slower than the queue drains
		for (int i = 0; i < n_wr; i++) begin
			r_tmp = rand16();
			case (r_tmp[1:0])
				2'd0: r_region = `REGION_LTH0;
				2'd1: r_region = `REGION_LTH1;
				2'd2: r_region = `REGION_LTH2;
				default: r_region = `REGION_BANK;
			endcase
			r_tmp  = rand16();
			r_addr = {r_region, r_tmp[9:0]};
			r_tmp  = rand16();
			r_data = r_tmp[7:0];
			bus_write(r_addr, r_data);
			exp_regs = apply_write(exp_regs, r_addr, r_data);
			repeat (4) @(posedge clk_6m);
		end
		repeat (12) @(posedge clk_6m);
		chk_regs <= 1'b1;
		@(posedge clk_6m);
		chk_regs <= 1'b0;
		@(negedge clk_6m);
		assert (overflow === 1'b0) else
			report_mismatch("overflow", overflow, 1'b0);

		// back to back back-color writes overrun the queue
		for (int i = 0; i < 8; i++) begin
			@(posedge clk_6m);
			r_tmp = rand16();
			a   <= {`REGION_LTH2, 10'(i)};
			d   <= r_tmp[7:0];
			we  <= 1'b1;
			acc <= 1'b1;
		end
		@(posedge clk_6m);
		acc <= 1'b0;
		we  <= 1'b0;
		expect_within(2, 1'b1, 4, "overflow after the write burst");
		// sticky from here until the closing reset
		@(posedge clk_6m);
		chk_ovf <= 1'b1;

		// vblank interrupt and its acknowledge at 8400h
		@(posedge clk_6m);
		vblk <= 1'b1;
		expect_within(0, 1'b1, 2, "irq rising after vblank");
		repeat (vb_high) @(posedge clk_6m);
		vblk <= 1'b0;
		repeat (4) @(posedge clk_6m);
		bus_write(16'h8400, 8'h00);
		expect_within(0, 1'b0, 2, "irq falling after the acknowledge write");

		// watchdog kick first drops the count left by the irq vblank
		bus_write(16'h8000, 8'h00);
		repeat (4) @(posedge clk_6m);
		for (int p = 0; p < 7; p++) begin
			vblank_pulse();
		end
		@(negedge clk_6m);
		assert (res === 1'b0) else
			report_mismatch("res", res, 1'b0);
		@(posedge clk_6m);
		vblk <= 1'b1;
		expect_within(1, 1'b1, 2, "res rising on the eighth vblank");
		repeat (vb_high) @(posedge clk_6m);
		vblk <= 1'b0;
		repeat (8) @(posedge clk_6m);
		bus_write(16'h8000, 8'h00);
		expect_within(1, 1'b0, 2, "res clearing after a kick");

		// closing reset clears overflow and the latches
		@(posedge clk_6m);
		rst     <= 1'b1;
		chk_ovf <= 1'b0;
		repeat (2) @(posedge clk_6m);
		@(negedge clk_6m);
		assert (overflow === 1'b0) else
			report_mismatch("overflow", overflow, 1'b0);
		assert (regs === '0) else
			report_mismatch("regs", regs, '0);
		@(posedge clk_6m);
		rst <= 1'b0;
		repeat (4) @(posedge clk_6m);

		$display("errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

/* logic/bus_decoder.sv */
`include "sub_bus_defs.svh"

module bus_decoder
	import bus_pkg::*;
(
	input  logic        clk_6m,
	input  logic        rst,
	input  logic        acc,
	input  logic        we,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	output chip_sel_t   sel,
	output logic        wr_valid,
	output latch_wr_t   wr_entry,
	output bus_event_t  ev
);

	// upper six address bits pick the region
	logic [5:0] region;

	latch_wr_t  entry_nxt;
	logic       valid_nxt;
	bus_event_t ev_nxt;

	assign region = a[15:10];

	////////////////////////////////////////////////////////////////////////////
	// chip selects, purely combinational
	////////////////////////////////////////////////////////////////////////////

	// 0000h-5fffh video and sprite ram in 8k blocks
	assign sel.scr0 = (a[15:13] == 3'b000);
	assign sel.scr1 = (a[15:13] == 3'b001);
	assign sel.obj  = (a[15:13] == 3'b010);
	// sound shared ram sits on top of the sprite ram window
	assign sel.snd  = (region == 6'b010000);

	// program roms, reads only
	assign sel.spgm = !we && (a[15:13] == 3'b011);
	assign sel.mpgm = !we && a[15];

	// write-only latches
	assign sel.bank = we && (region == `REGION_BANK);
	assign sel.lth0 = we && (region == `REGION_LTH0);
	assign sel.lth1 = we && (region == `REGION_LTH1);
	assign sel.lth2 = we && (region == `REGION_LTH2);

	// data bus buffer toward the video side
	assign sel.bufen = sel.scr0 | sel.scr1 | sel.obj | sel.snd | sel.lth0 | sel.lth1;

	////////////////////////////////////////////////////////////////////////////
	// latch write entries
	////////////////////////////////////////////////////////////////////////////

	always_comb begin
		entry_nxt.op    = op_xlo;
		entry_nxt.layer = 2'd0;
		entry_nxt.data  = d;
		valid_nxt       = 1'b0;
		if (sel.lth0 || sel.lth1) begin
			// a[2] picks the second layer of the pair
			entry_nxt.layer = {sel.lth1, a[2]};
			valid_nxt       = acc;
			case (a[1:0])
				2'd0: entry_nxt.op = op_xhi_pri;
				2'd1: entry_nxt.op = op_xlo;
				2'd2: entry_nxt.op = op_y;
				default: begin
					// offset 3 is the rom bank, offset 7 goes nowhere
					entry_nxt.op    = op_rom_bank;
					entry_nxt.layer = {1'b0, sel.lth1};
					valid_nxt       = acc && !a[2];
				end
			endcase
		end else if (sel.lth2) begin
			entry_nxt.op = op_back_color;
			valid_nxt    = acc;
		end else if (sel.bank) begin
			entry_nxt.op = op_tile_bank;
			valid_nxt    = acc;
		end
	end

	// kick and ack carry no data, they only strobe
	assign ev_nxt.wd_kick = acc && we && (region == `REGION_KICK);
	assign ev_nxt.irq_ack = acc && we && (region == `REGION_ACK);

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			wr_valid <= 1'b0;
			ev       <= '0;
		end else begin
			wr_valid <= valid_nxt;
			ev       <= ev_nxt;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (valid_nxt) begin
			wr_entry <= entry_nxt;
		end
	end

	// latch regions and event regions are disjoint
	a_wr_ev_exclusive : assert property (
		@(posedge clk_6m) disable iff (rst)
		!(wr_valid && (ev.wd_kick || ev.irq_ack))
	);

endmodule

/* logic/bus_pkg.sv */
package bus_pkg;

	////////////////////////////////////////////////////////////////////////////
	// cpu clocking and bus decode types
	////////////////////////////////////////////////////////////////////////////

	// quadrature clocks for the two 6809-style cpus
	typedef struct packed {
		logic e_main;
		logic q_main;
		logic e_sub;
		logic q_sub;
	} cpu_phase_t;

	// chip selects out of the sub cpu address decode
	typedef struct packed {
		logic scr0;
		logic scr1;
		logic obj;
		logic snd;
		logic spgm;
		logic mpgm;
		logic bank;
		logic lth0;
		logic lth1;
		logic lth2;
		logic bufen;
	} chip_sel_t;

	// single-cycle control pulses from bus writes
	typedef struct packed {
		logic wd_kick;
		logic irq_ack;
	} bus_event_t;

	// which latch field a queued write targets
	typedef enum logic [2:0] {
		op_xhi_pri,
		op_xlo,
		op_y,
		op_rom_bank,
		op_back_color,
		op_tile_bank
	} latch_op_t;

	// one queued latch write
	typedef struct packed {
		latch_op_t   op;
		logic [1:0]  layer;
		logic [7:0]  data;
	} latch_wr_t;

endpackage

/* logic/cpu_phase_gen.sv */
module cpu_phase_gen
	import bus_pkg::*;
(
	input  logic       clk_6m,
	input  logic       rst,
	output cpu_phase_t phase,
	output logic       cycle_end
);

	// two bit phase counter stepping once per pixel clock
	// four pixel clocks make one bus cycle of 1.5 MHz E
	logic [1:0] cnt;

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			cnt <= 2'd0;
		end else begin
			cnt <= cnt + 2'd1;
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// quadrature decode
	////////////////////////////////////////////////////////////////////////////

	// main cpu q leads e by a quarter cycle
	// e high at counts 2,3
	assign phase.e_main = cnt[1];
	// q high at counts 1,2
	assign phase.q_main = cnt[1] ^ cnt[0];

	// sub cpu runs half a cycle away from main
	// so the two never own the shared bus together
	// e high at counts 0,1
	assign phase.e_sub = ~cnt[1];
	// q high at counts 3,0
	assign phase.q_sub = ~(cnt[1] ^ cnt[0]);

	// last count of the cycle before sub e falls
	assign cycle_end = (cnt == 2'd3);

	// both cpus driving E together would mean a bus clash
	a_e_exclusive : assert property (
		@(posedge clk_6m) disable iff (rst)
		!(phase.e_main && phase.e_sub)
	);

endmodule

/* logic/sub_bus_defs.svh */
`ifndef SUB_BUS_DEFS_SVH
`define SUB_BUS_DEFS_SVH

////////////////////////////////////////////////////////////////////////////
// sub cpu bus glue constants
////////////////////////////////////////////////////////////////////////////

// watchdog counter width, msb drives the reset output
// four bits gives eight vblanks before reset fires
`define WATCHDOG_WIDTH 4

// latch write queue depth
`define QUEUE_DEPTH 4

// upper address bits a[15:10] of the write-only control regions
// 8000h watchdog kick
`define REGION_KICK 6'b100000
// 8400h vblank interrupt acknowledge
`define REGION_ACK 6'b100001
// 8c00h tile bank select
`define REGION_BANK 6'b100011
// 9000h scroll/priority for layers 0 and 1, rom bank 9d
`define REGION_LTH0 6'b100100
// 9400h scroll/priority for layers 2 and 3, rom bank 12d
`define REGION_LTH1 6'b100101
// a000h back color
`define REGION_LTH2 6'b101000

`endif

/* logic/sub_cpu_bus.sv */
module sub_cpu_bus
	import bus_pkg::*;
	import video_reg_pkg::*;
(
	input  logic        clk_6m,
	input  logic        rst,
	input  logic        vblk,
	input  logic        we,
	input  logic        acc,
	input  logic [15:0] a,
	input  logic [7:0]  d,
	output cpu_phase_t  phase,
	output chip_sel_t   sel,
	output logic        res,
	output logic        irq,
	output video_regs_t regs,
	output logic        overflow
);

	// bus cycle boundary from the phase generator
	logic       cycle_end;

	// decoder to queue
	logic       wr_valid;
	latch_wr_t  wr_entry;
	// decoder to watchdog
	bus_event_t ev;

	// queue to latch bank
	latch_wr_t  head;
	logic       not_empty;
	logic       pop;

	cpu_phase_gen phase_i (
		.clk_6m    (clk_6m),
		.rst       (rst),
		.phase     (phase),
		.cycle_end (cycle_end)
	);

	bus_decoder decode_i (
		.clk_6m   (clk_6m),
		.rst      (rst),
		.acc      (acc),
		.we       (we),
		.a        (a),
		.d        (d),
		.sel      (sel),
		.wr_valid (wr_valid),
		.wr_entry (wr_entry),
		.ev       (ev)
	);

	write_queue queue_i (
		.clk_6m    (clk_6m),
		.rst       (rst),
		.push      (wr_valid),
		.entry_in  (wr_entry),
		.pop       (pop),
		.head      (head),
		.not_empty (not_empty),
		.overflow  (overflow)
	);

	video_latch_bank latch_i (
		.clk_6m    (clk_6m),
		.rst       (rst),
		.cycle_end (cycle_end),
		.not_empty (not_empty),
		.head      (head),
		.pop       (pop),
		.regs      (regs)
	);

	sys_watchdog wdog_i (
		.clk_6m (clk_6m),
		.rst    (rst),
		.vblk   (vblk),
		.ev     (ev),
		.res    (res),
		.irq    (irq)
	);

endmodule

/* logic/sys_watchdog.sv */
`include "sub_bus_defs.svh"

module sys_watchdog
	import bus_pkg::*;
(
	input  logic       clk_6m,
	input  logic       rst,
	input  logic       vblk,
	input  bus_event_t ev,
	output logic       res,
	output logic       irq
);

	logic                       vblk_q;
	logic                       vblk_rise;
	logic [`WATCHDOG_WIDTH-1:0] wd_cnt;

	////////////////////////////////////////////////////////////////////////////
	// vblank edge
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			vblk_q <= 1'b0;
		end else begin
			vblk_q <= vblk;
		end
	end

	assign vblk_rise = vblk && !vblk_q;

	////////////////////////////////////////////////////////////////////////////
	// watchdog and interrupt
	////////////////////////////////////////////////////////////////////////////

	// counts vblanks, kick clears it
	// stops once the msb is up so reset stays asserted
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			wd_cnt <= '0;
		end else if (ev.wd_kick) begin
			wd_cnt <= '0;
		end else if (vblk_rise && !res) begin
			wd_cnt <= wd_cnt + 1'b1;
		end
	end

	assign res = wd_cnt[`WATCHDOG_WIDTH-1];

	// vblank irq, a new vblank beats an ack in the same cycle
	always_ff @(posedge clk_6m) begin
		if (rst) begin
			irq <= 1'b0;
		end else if (vblk_rise) begin
			irq <= 1'b1;
		end else if (ev.irq_ack) begin
			irq <= 1'b0;
		end
	end

	// reset only releases through a kick from the cpu
	a_res_release : assert property (
		@(posedge clk_6m)
		$fell(res) |-> ($past(ev.wd_kick) || $past(rst))
	);

endmodule

/* logic/video_latch_bank.sv */
module video_latch_bank
	import bus_pkg::*;
	import video_reg_pkg::*;
(
	input  logic        clk_6m,
	input  logic        rst,
	input  logic        cycle_end,
	input  logic        not_empty,
	input  latch_wr_t   head,
	output logic        pop,
	output video_regs_t regs
);

	// one latch update per bus cycle as the real latches
	// only see a strobe once per sub cpu cycle
	assign pop = cycle_end && not_empty;

	////////////////////////////////////////////////////////////////////////////
	// register update
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			regs <= '0;
		end else if (pop) begin
			case (head.op)
				op_xhi_pri: begin
					// x msb and priority share one byte
					regs.layer[head.layer].x[8] <= head.data[0];
					regs.layer[head.layer].pri  <= head.data[3:1];
				end
				op_xlo: begin
					regs.layer[head.layer].x[7:0] <= head.data;
				end
				op_y: begin
					regs.layer[head.layer].y <= head.data;
				end
				op_rom_bank: begin
					// layer 0 selects the 9d rom and layer 1 the 12d rom
					if (head.layer[0]) begin
						regs.rom_bank_12d <= head.data[2:0];
					end else begin
						regs.rom_bank_9d <= head.data[2:0];
					end
				end
				op_back_color: begin
					regs.back_color <= head.data;
				end
				op_tile_bank: begin
					regs.tile_bank <= head.data[0];
				end
				default: begin
					// unused encodings leave the latches alone
					regs <= regs;
				end
			endcase
		end
	end

endmodule

/* logic/video_reg_pkg.sv */
package video_reg_pkg;

	////////////////////////////////////////////////////////////////////////////
	// video latch register file
	////////////////////////////////////////////////////////////////////////////

	// scroll and priority of one tilemap layer
	typedef struct packed {
		// nine bit x, msb written with the priority
		logic [8:0] x;
		logic [7:0] y;
		// layer priority, 0 is furthest back
		logic [2:0] pri;
	} layer_scroll_t;

	// all latches held for the tilemap side
	typedef struct packed {
		// layers 0 to 3, index matches the entry layer field
		layer_scroll_t [3:0] layer;
		// rom bank for the 9d tile rom
		logic [2:0]          rom_bank_9d;
		// rom bank for the 12d tile rom
		logic [2:0]          rom_bank_12d;
		logic                tile_bank;
		// palette index behind all layers
		logic [7:0]          back_color;
	} video_regs_t;

endpackage

/* logic/write_queue.sv */
`include "sub_bus_defs.svh"

module write_queue
	import bus_pkg::*;
#(
	parameter int depth = `QUEUE_DEPTH
) (
	input  logic      clk_6m,
	input  logic      rst,
	input  logic      push,
	input  latch_wr_t entry_in,
	input  logic      pop,
	output latch_wr_t head,
	output logic      not_empty,
	output logic      overflow
);

	localparam int aw = (depth > 1) ? $clog2(depth) : 1;
	localparam logic [aw:0]   full_cnt = (aw + 1)'(depth);
	localparam logic [aw-1:0] last_ptr = aw'(depth - 1);

	// entry storage
	latch_wr_t mem [depth];

	logic [aw-1:0] rd_ptr;
	logic [aw-1:0] wr_ptr;
	logic [aw:0]   count;
	logic          full;
	logic          do_push;

	assign full      = (count == full_cnt);
	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	// a pop in the same cycle frees the slot for a push when full
	assign do_push = push && (!full || pop);

	always_ff @(posedge clk_6m) begin
		if (do_push) begin
			mem[wr_ptr] <= entry_in;
		end
	end

	always_ff @(posedge clk_6m) begin
		if (rst) begin
			rd_ptr   <= '0;
			wr_ptr   <= '0;
			count    <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == last_ptr) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == last_ptr) ? '0 : rd_ptr + 1'b1;
			end
			// count only moves when one side acts alone
			if (do_push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !do_push) begin
				count <= count - 1'b1;
			end
			// dropped write, sticky until reset
			if (push && !do_push) begin
				overflow <= 1'b1;
			end
		end
	end

	a_no_pop_empty : assert property (
		@(posedge clk_6m) disable iff (rst)
		pop |-> not_empty
	);

	a_count_bound : assert property (
		@(posedge clk_6m) disable iff (rst)
		count <= full_cnt
	);

endmodule

/* run.sh */
#!/bin/sh
# build and run the sub cpu bus testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	-f sources.f \
	--top-module sub_cpu_bus_tb \
	-o sub_cpu_bus_sim

./obj_dir/sub_cpu_bus_sim > sim.log 2>&1
cat sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation reported failure"
	exit 1
fi
echo "simulation finished without failure"

/* sources.f */
+incdir+logic
logic/bus_pkg.sv
logic/video_reg_pkg.sv
logic/cpu_phase_gen.sv
logic/bus_decoder.sv
logic/write_queue.sv
logic/video_latch_bank.sv
logic/sys_watchdog.sv
logic/sub_cpu_bus.sv
bench/sub_cpu_bus_tb.sv
